//--- usb3_lite.f
+incdir+.
usb3_pkg.sv
usb3_word_fifo.sv
usb3_pipe_gearbox.sv
usb3_ltssm.sv
usb3_link_regs.sv
usb3_lite_top.sv
tb_clkgen.sv
tb_usb3_lite.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the usb3_lite testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
	--top-module tb_usb3_lite -f usb3_lite.f

# a failing run still leaves its log for the search below
./obj_dir/Vtb_usb3_lite > sim.log 2>&1 || true
cat sim.log

if grep -q "^PASS: all tests$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

//--- tb_usb3_lite.sv
// usb3 lite testbench
`timescale 1ns/1ns
`include "usb3_lite_consts.svh"

module tb_usb3_lite;

	localparam int CLK_NS = 100;
	// cycles for reset, detect, tx fill, training, tx drain, rx and warm reset
	localparam int BUDGET = 30 + 20 + 45 + 70 + 40 + 120 + 20;

	logic                     local_pclk_half;
	logic                     rst_n;
	logic                     phy_pwrpresent;
	logic [`USB3_APB_AW-1:0]  paddr;
	logic                     psel;
	logic                     penable;
	logic                     pwrite;
	logic [`USB3_APB_DW-1:0]  pwdata;
	logic [`USB3_APB_DW-1:0]  prdata;
	logic [`USB3_PIPE_W-1:0]  phy_pipe_rx_data;
	logic [`USB3_PIPE_KW-1:0] phy_pipe_rx_datak;
	logic                     phy_pipe_rx_valid;
	logic [2:0]               phy_rx_status;
	logic [`USB3_PIPE_W-1:0]  phy_pipe_tx_data;
	logic [`USB3_PIPE_KW-1:0] phy_pipe_tx_datak;
	logic                     phy_tx_detrx_lpbk;
	logic                     phy_tx_elecidle;
	logic [2:0]               phy_tx_margin;

	logic [17:0] tx_q[$];	// {datak, data} per transmitted half
	int          seed = 32'h48a9;

	tb_clkgen #(.PERIOD(CLK_NS)) i_clkgen (.clk(local_pclk_half));

	usb3_lite_top i_usb3_lite_top (.*);

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "run stopped");
	endtask

	task automatic check_eq(input string name, input logic [35:0] got, input logic [35:0] exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
			$display("FAIL: see errors above");
			$fatal(1, "check failed");
		end
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		@(posedge local_pclk_half);
		paddr   <= addr;
		pwdata  <= data;
		pwrite  <= 1'b1;
		psel    <= 1'b1;
		@(posedge local_pclk_half);
		penable <= 1'b1;
		@(posedge local_pclk_half);	// access edge
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
		@(posedge local_pclk_half);
		paddr   <= addr;
		pwrite  <= 1'b0;
		psel    <= 1'b1;
		@(posedge local_pclk_half);
		penable <= 1'b1;
		@(negedge local_pclk_half);
		data = prdata;
		@(posedge local_pclk_half);	// rxdata pops here
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	// low beat first, then high beat, then one idle cycle
	task automatic send_word(input logic [3:0] k, input logic [31:0] d);
		@(posedge local_pclk_half);
		phy_pipe_rx_valid <= 1'b1;
		phy_pipe_rx_data  <= d[15:0];
		phy_pipe_rx_datak <= k[1:0];
		@(posedge local_pclk_half);
		phy_pipe_rx_data  <= d[31:16];
		phy_pipe_rx_datak <= k[3:2];
		@(posedge local_pclk_half);
		phy_pipe_rx_valid <= 1'b0;
	endtask

	task automatic expect_state(input logic [2:0] exp);
		logic [31:0] rd;
		apb_read(`USB3_A_STATUS, rd);
		check_eq("status.state", rd[2:0], exp);
	endtask

	function automatic logic [31:0] tx_word(input int i);
		return {16'hA000 + 16'(i), 16'h5000 + 16'(i)};
	endfunction

	// nonzero halves on the pipe while the link is out of electrical idle
	always @(negedge local_pclk_half) begin
		if (phy_tx_elecidle === 1'b0 && {phy_pipe_tx_datak, phy_pipe_tx_data} != '0)
			tx_q.push_back({phy_pipe_tx_datak, phy_pipe_tx_data});
	end

	////////////////////////////////////////
	// tests
	////////////////////////////////////////

	task automatic reset_and_straps();
		logic [31:0] rd;
		repeat (4) @(posedge local_pclk_half);
		@(negedge local_pclk_half);
		check_eq("phy_tx_margin", phy_tx_margin, `USB3_STRAP_MARGIN);
		repeat (12) @(posedge local_pclk_half);
		rst_n <= 1'b1;	// 16 cycles held
		repeat (3) @(posedge local_pclk_half);
		@(negedge local_pclk_half);
		check_eq("phy_tx_margin", phy_tx_margin, 3'b000);
		check_eq("phy_tx_elecidle", phy_tx_elecidle, 1'b1);
		check_eq("phy_tx_detrx_lpbk", phy_tx_detrx_lpbk, 1'b0);
		check_eq("phy_pipe_tx_data", phy_pipe_tx_data, 16'h0000);
		check_eq("phy_pipe_tx_datak", phy_pipe_tx_datak, 2'b00);
		expect_state(usb3_pkg::DISABLED);
		apb_read(`USB3_A_RXCNT, rd);
		check_eq("rxcnt", rd, 32'd0);
	endtask

	task automatic detect_and_poll();
		apb_write(`USB3_A_CTRL, 32'h1);
		expect_state(usb3_pkg::RX_DETECT);
		@(negedge local_pclk_half);
		check_eq("phy_tx_detrx_lpbk", phy_tx_detrx_lpbk, 1'b1);
		@(posedge local_pclk_half);
		phy_rx_status <= `USB3_RXSTAT_PRESENT;
		expect_state(usb3_pkg::POLLING);
		@(posedge local_pclk_half);
		phy_rx_status <= 3'b000;	// keep later warm reset parked in rx_detect
	endtask

	task automatic fill_tx_fifo();
		logic [31:0] rd;
		int          i;
		apb_write(`USB3_A_TXK, 32'h6);
		for (i = 0; i < 8; i++)
			apb_write(`USB3_A_TXDATA, tx_word(i));
		apb_read(`USB3_A_STATUS, rd);
		check_eq("status.tx_full", rd[9], 1'b1);
		check_eq("status.state", rd[2:0], usb3_pkg::POLLING);
		apb_write(`USB3_A_TXDATA, 32'hDEAD_BEEF);	// must be dropped
		apb_read(`USB3_A_STATUS, rd);
		check_eq("status.tx_full", rd[9], 1'b1);
	endtask

	task automatic train_link();
		logic [31:0] ts;
		ts = {4{`USB3_K_COM}};
		repeat (7) send_word(4'hF, ts);
		send_word(4'h0, 32'h1234_5678);	// breaks the run
		repeat (7) send_word(4'hF, ts);
		expect_state(usb3_pkg::POLLING);
		send_word(4'hF, ts);
		expect_state(usb3_pkg::U0);
		@(negedge local_pclk_half);
		check_eq("phy_tx_elecidle", phy_tx_elecidle, 1'b0);
	endtask

	task automatic drain_tx_fifo();
		logic [31:0] w;
		int          n;
		int          i;
		n = 0;
		while (tx_q.size() < 16 && n < 40) begin
			@(posedge local_pclk_half);
			n++;
		end
		if (tx_q.size() < 16)
			fail_run("transmit words did not all reach the pipe");
		repeat (6) @(posedge local_pclk_half);
		check_eq("tx_half_count", tx_q.size(), 16);
		for (i = 0; i < 8; i++) begin
			w = tx_word(i);
			check_eq("phy_pipe_tx low half", tx_q[2*i], {2'b10, w[15:0]});
			check_eq("phy_pipe_tx high half", tx_q[2*i+1], {2'b01, w[31:16]});
		end
	endtask

	task automatic receive_words();
		logic [3:0]  k [10];
		logic [31:0] d [10];
		logic [31:0] rd;
		logic [31:0] rnd;
		int          b;
		int          i;
		// two batches of five since the fifo only holds eight
		for (b = 0; b < 2; b++) begin
			for (i = 5 * b; i < 5 * b + 5; i++) begin
				rnd  = $random(seed);
				k[i] = rnd[3:0];
				d[i] = $random(seed);
				send_word(k[i], d[i]);
			end
			for (i = 5 * b; i < 5 * b + 5; i++) begin
				apb_read(`USB3_A_RXK, rd);
				check_eq("rxk", rd, {28'd0, k[i]});
				apb_read(`USB3_A_RXDATA, rd);
				check_eq("rxdata", rd, d[i]);
			end
		end
		apb_read(`USB3_A_RXCNT, rd);
		check_eq("rxcnt", rd, 32'd10);
		apb_read(`USB3_A_STATUS, rd);
		check_eq("status.rx_not_empty", rd[8], 1'b0);
		apb_read(`USB3_A_RXDATA, rd);
		check_eq("rxdata when empty", rd, 32'd0);
	endtask

	task automatic warm_reset_and_power();
		apb_write(`USB3_A_CTRL, 32'h3);	// enable stays set and warm reset pulses
		expect_state(usb3_pkg::RX_DETECT);
		@(negedge local_pclk_half);
		check_eq("phy_tx_detrx_lpbk", phy_tx_detrx_lpbk, 1'b1);
		@(posedge local_pclk_half);
		phy_pwrpresent <= 1'b0;
		expect_state(usb3_pkg::DISABLED);
		@(negedge local_pclk_half);
		check_eq("phy_tx_detrx_lpbk", phy_tx_detrx_lpbk, 1'b0);
		check_eq("phy_tx_elecidle", phy_tx_elecidle, 1'b1);
		check_eq("phy_tx_margin", phy_tx_margin, `USB3_STRAP_MARGIN);
	endtask

	////////////////////////////////////////
	// main sequence and watchdog
	////////////////////////////////////////

	initial begin
		rst_n             = 1'b0;
		phy_pwrpresent    = 1'b1;
		paddr             = '0;
		psel              = 1'b0;
		penable           = 1'b0;
		pwrite            = 1'b0;
		pwdata            = '0;
		phy_pipe_rx_data  = '0;
		phy_pipe_rx_datak = '0;
		phy_pipe_rx_valid = 1'b0;
		phy_rx_status     = 3'b000;
		reset_and_straps();
		detect_and_poll();
		fill_tx_fifo();
		train_link();
		drain_tx_fifo();
		receive_words();
		warm_reset_and_power();
		$display("PASS: all tests");
		$finish;
	end

	initial begin
		#(2 * BUDGET * CLK_NS);
		fail_run("watchdog expired before the tests finished");
	end

endmodule

//--- tb_clkgen.sv
// testbench clock generator
`timescale 1ns/1ns

module tb_clkgen #(
	parameter int PERIOD = 100
) (
	output logic clk
);

	initial clk = 1'b0;

	always #(PERIOD / 2) clk = ~clk;	// 50 ns high, 50 ns low

endmodule

//--- usb3_lite_top.sv
// usb3 lite top level
`timescale 1ns/1ns
`include "usb3_lite_consts.svh"

module usb3_lite_top (
	input  logic                     local_pclk_half,
	input  logic                     rst_n,
	input  logic                     phy_pwrpresent,
	input  logic [`USB3_APB_AW-1:0]  paddr,
	input  logic                     psel,
	input  logic                     penable,
	input  logic                     pwrite,
	input  logic [`USB3_APB_DW-1:0]  pwdata,
	output logic [`USB3_APB_DW-1:0]  prdata,
	input  logic [`USB3_PIPE_W-1:0]  phy_pipe_rx_data,
	input  logic [`USB3_PIPE_KW-1:0] phy_pipe_rx_datak,
	input  logic                     phy_pipe_rx_valid,
	input  logic [2:0]               phy_rx_status,
	output logic [`USB3_PIPE_W-1:0]  phy_pipe_tx_data,
	output logic [`USB3_PIPE_KW-1:0] phy_pipe_tx_datak,
	output logic                     phy_tx_detrx_lpbk,
	output logic                     phy_tx_elecidle,
	output logic [2:0]               phy_tx_margin
);

	logic                   rst_meta_n;
	logic                   rst_sync_n;	// internal reset for all blocks
	usb3_pkg::link_word_t   link_in_word;
	logic                   link_in_active;
	usb3_pkg::link_word_t   link_out_word;
	logic                   link_out_valid;
	logic                   link_out_ready;
	usb3_pkg::ltssm_state_t ltssm_state;
	logic                   link_up;
	logic                   link_enable;
	logic                   warm_reset;

	// two flop sync released once board reset and vbus are both good
	always_ff @(posedge local_pclk_half) begin
		{rst_sync_n, rst_meta_n} <= {rst_meta_n, rst_n & phy_pwrpresent};
	end

	// strap value seen by the phy while held in reset
	assign phy_tx_margin = rst_sync_n ? 3'b000 : `USB3_STRAP_MARGIN;

	////////////////////////////////////////
	// blocks
	////////////////////////////////////////

	usb3_pipe_gearbox i_gearbox (
		.local_pclk_half (local_pclk_half), .rst_n (rst_sync_n), .link_up (link_up),
		.phy_pipe_rx_data (phy_pipe_rx_data), .phy_pipe_rx_datak (phy_pipe_rx_datak),
		.phy_pipe_rx_valid (phy_pipe_rx_valid),
		.link_in_word (link_in_word), .link_in_active (link_in_active),
		.link_out_word (link_out_word), .link_out_valid (link_out_valid),
		.link_out_ready (link_out_ready),
		.phy_pipe_tx_data (phy_pipe_tx_data), .phy_pipe_tx_datak (phy_pipe_tx_datak)
	);

	usb3_ltssm i_ltssm (
		.local_pclk_half (local_pclk_half), .rst_n (rst_sync_n),
		.link_enable (link_enable), .warm_reset (warm_reset),
		.phy_pwrpresent (phy_pwrpresent), .phy_rx_status (phy_rx_status),
		.link_in_word (link_in_word), .link_in_active (link_in_active),
		.ltssm_state (ltssm_state), .link_up (link_up),
		.phy_tx_detrx_lpbk (phy_tx_detrx_lpbk), .phy_tx_elecidle (phy_tx_elecidle)
	);

	usb3_link_regs i_regs (
		.local_pclk_half (local_pclk_half), .rst_n (rst_sync_n),
		.paddr (paddr), .psel (psel), .penable (penable), .pwrite (pwrite),
		.pwdata (pwdata), .prdata (prdata),
		.ltssm_state (ltssm_state), .link_up (link_up),
		.link_in_word (link_in_word), .link_in_active (link_in_active),
		.link_out_word (link_out_word), .link_out_valid (link_out_valid),
		.link_out_ready (link_out_ready),
		.link_enable (link_enable), .warm_reset (warm_reset)
	);

endmodule

//--- usb3_link_regs.sv
// usb3 lite apb registers
`timescale 1ns/1ns
`include "usb3_lite_consts.svh"

module usb3_link_regs (
	input  logic                    local_pclk_half,
	input  logic                    rst_n,
	input  logic [`USB3_APB_AW-1:0] paddr,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  logic [`USB3_APB_DW-1:0] pwdata,
	output logic [`USB3_APB_DW-1:0] prdata,
	input  usb3_pkg::ltssm_state_t  ltssm_state,
	input  logic                    link_up,
	input  usb3_pkg::link_word_t    link_in_word,
	input  logic                    link_in_active,
	output usb3_pkg::link_word_t    link_out_word,
	output logic                    link_out_valid,
	input  logic                    link_out_ready,
	output logic                    link_enable,
	output logic                    warm_reset
);

	logic                     apb_wr;
	logic                     apb_rd;
	logic [`USB3_LINK_KW-1:0] txk;
	logic [`USB3_APB_DW-1:0]  rxcnt;
	usb3_pkg::link_word_t     tx_push_word;
	usb3_pkg::link_word_t     rx_head;
	logic                     tx_push;
	logic                     tx_empty;
	logic                     tx_full;
	logic                     rx_push;
	logic                     rx_pop;
	logic                     rx_empty;
	logic                     rx_full;

	assign apb_wr = psel && penable && pwrite;	// access phase only
	assign apb_rd = psel && penable && !pwrite;

	////////////////////////////////////////
	// control registers
	////////////////////////////////////////

	always_ff @(posedge local_pclk_half) begin
		if (!rst_n) begin
			link_enable <= 1'b0;
			warm_reset  <= 1'b0;
			txk         <= '0;
			rxcnt       <= '0;
		end else begin
			warm_reset <= apb_wr && (paddr == `USB3_A_CTRL) && pwdata[1];	// self clearing
			if (apb_wr && paddr == `USB3_A_CTRL)
				link_enable <= pwdata[0];
			if (apb_wr && paddr == `USB3_A_TXK)
				txk <= pwdata[`USB3_LINK_KW-1:0];
			if (link_in_active && link_up)
				rxcnt <= rxcnt + 1'b1;
		end
	end

	////////////////////////////////////////
	// fifos
	////////////////////////////////////////

	assign tx_push_word.datak = txk;
	assign tx_push_word.data  = pwdata;
	assign tx_push            = apb_wr && (paddr == `USB3_A_TXDATA) && !tx_full;
	assign link_out_valid     = !tx_empty;

	usb3_word_fifo #(.payload_t(usb3_pkg::link_word_t)) i_tx_fifo (
		.local_pclk_half (local_pclk_half),
		.rst_n           (rst_n),
		.push            (tx_push),
		.push_data       (tx_push_word),
		.pop             (link_out_valid && link_out_ready),
		.pop_data        (link_out_word),
		.empty           (tx_empty),
		.full            (tx_full)
	);

	assign rx_push = link_in_active && link_up && !rx_full;	// overflow drops the word
	assign rx_pop  = apb_rd && (paddr == `USB3_A_RXDATA) && !rx_empty;

	usb3_word_fifo #(.payload_t(usb3_pkg::link_word_t)) i_rx_fifo (
		.local_pclk_half (local_pclk_half),
		.rst_n           (rst_n),
		.push            (rx_push),
		.push_data       (link_in_word),
		.pop             (rx_pop),
		.pop_data        (rx_head),
		.empty           (rx_empty),
		.full            (rx_full)
	);

	// read mux
	always_comb begin
		case (paddr)
			`USB3_A_CTRL:   prdata = {31'd0, link_enable};
			`USB3_A_STATUS: prdata = {22'd0, tx_full, !rx_empty,
			                          {(8 - `USB3_STATE_W){1'b0}}, ltssm_state};
			`USB3_A_TXK:    prdata = {28'd0, txk};
			`USB3_A_RXK:    prdata = {28'd0, rx_head.datak};
			`USB3_A_RXDATA: prdata = rx_empty ? '0 : rx_head.data;
			`USB3_A_RXCNT:  prdata = rxcnt;
			default:        prdata = '0;
		endcase
	end

endmodule

//--- usb3_ltssm.sv
// usb3 lite link training
`timescale 1ns/1ns
`include "usb3_lite_consts.svh"

module usb3_ltssm (
	input  logic                   local_pclk_half,
	input  logic                   rst_n,
	input  logic                   link_enable,
	input  logic                   warm_reset,
	input  logic                   phy_pwrpresent,
	input  logic [2:0]             phy_rx_status,
	input  usb3_pkg::link_word_t   link_in_word,
	input  logic                   link_in_active,
	output usb3_pkg::ltssm_state_t ltssm_state,
	output logic                   link_up,
	output logic                   phy_tx_detrx_lpbk,
	output logic                   phy_tx_elecidle
);

	localparam int TW = $clog2(`USB3_TS_NEEDED + 1);

	usb3_pkg::ltssm_state_t state_nxt;
	logic [TW-1:0]          ts_cnt;
	logic                   is_ts;

	// training word is four commas, all flagged as k
	assign is_ts = (link_in_word.datak == '1) &&
	               (link_in_word.data == {4{`USB3_K_COM}});

	always_comb begin
		state_nxt = ltssm_state;
		case (ltssm_state)
			usb3_pkg::DISABLED:
				if (link_enable)
					state_nxt = usb3_pkg::RX_DETECT;
			usb3_pkg::RX_DETECT:
				if (phy_rx_status == `USB3_RXSTAT_PRESENT)
					state_nxt = usb3_pkg::POLLING;
			usb3_pkg::POLLING:
				if (link_in_active && is_ts && ts_cnt == TW'(`USB3_TS_NEEDED - 1))
					state_nxt = usb3_pkg::U0;
			default: ;	// U0 holds
		endcase
		// overrides where power loss wins
		if (warm_reset)
			state_nxt = usb3_pkg::RX_DETECT;
		if (!link_enable || !phy_pwrpresent)
			state_nxt = usb3_pkg::DISABLED;
	end

	always_ff @(posedge local_pclk_half) begin
		if (!rst_n) begin
			ltssm_state <= usb3_pkg::DISABLED;
			ts_cnt      <= '0;
		end else begin
			ltssm_state <= state_nxt;
			if (ltssm_state != usb3_pkg::POLLING)
				ts_cnt <= '0;
			else if (link_in_active)
				ts_cnt <= is_ts ? ts_cnt + 1'b1 : '0;	// any other word restarts
		end
	end

	assign link_up           = (ltssm_state == usb3_pkg::U0);
	assign phy_tx_detrx_lpbk = (ltssm_state == usb3_pkg::RX_DETECT);
	assign phy_tx_elecidle   = (ltssm_state != usb3_pkg::U0);

endmodule

//--- usb3_pipe_gearbox.sv
// usb3 lite pipe gearbox
`timescale 1ns/1ns
`include "usb3_lite_consts.svh"

module usb3_pipe_gearbox (
	input  logic                     local_pclk_half,
	input  logic                     rst_n,
	input  logic                     link_up,
	input  logic [`USB3_PIPE_W-1:0]  phy_pipe_rx_data,
	input  logic [`USB3_PIPE_KW-1:0] phy_pipe_rx_datak,
	input  logic                     phy_pipe_rx_valid,
	output usb3_pkg::link_word_t     link_in_word,
	output logic                     link_in_active,
	input  usb3_pkg::link_word_t     link_out_word,
	input  logic                     link_out_valid,
	output logic                     link_out_ready,
	output logic [`USB3_PIPE_W-1:0]  phy_pipe_tx_data,
	output logic [`USB3_PIPE_KW-1:0] phy_pipe_tx_datak
);

	////////////////////////////////////////
	// receive packing
	////////////////////////////////////////

	logic                     rx_half;	// low beat already held
	logic [`USB3_PIPE_W-1:0]  rx_lo_data;
	logic [`USB3_PIPE_KW-1:0] rx_lo_datak;

	always_ff @(posedge local_pclk_half) begin
		if (!rst_n) begin
			rx_half        <= 1'b0;
			link_in_active <= 1'b0;
		end else begin
			link_in_active <= phy_pipe_rx_valid && rx_half;
			if (phy_pipe_rx_valid)
				rx_half <= !rx_half;
		end
	end

	always_ff @(posedge local_pclk_half) begin
		if (phy_pipe_rx_valid && !rx_half) begin
			rx_lo_data  <= phy_pipe_rx_data;
			rx_lo_datak <= phy_pipe_rx_datak;
		end
		if (phy_pipe_rx_valid && rx_half) begin
			link_in_word.data  <= {phy_pipe_rx_data, rx_lo_data};
			link_in_word.datak <= {phy_pipe_rx_datak, rx_lo_datak};
		end
	end

	////////////////////////////////////////
	// transmit splitting
	////////////////////////////////////////

	logic                     tx_hi_pending;
	logic [`USB3_PIPE_W-1:0]  tx_hi_data;
	logic [`USB3_PIPE_KW-1:0] tx_hi_datak;
	logic                     tx_take;

	assign link_out_ready = link_up && !tx_hi_pending;
	assign tx_take        = link_out_valid && link_out_ready;

	always_ff @(posedge local_pclk_half) begin
		if (!rst_n || !link_up) begin
			tx_hi_pending     <= 1'b0;	// idle at zero outside U0
			phy_pipe_tx_data  <= '0;
			phy_pipe_tx_datak <= '0;
		end else if (tx_take) begin
			tx_hi_pending     <= 1'b1;
			phy_pipe_tx_data  <= link_out_word.data[`USB3_PIPE_W-1:0];
			phy_pipe_tx_datak <= link_out_word.datak[`USB3_PIPE_KW-1:0];
		end else if (tx_hi_pending) begin
			tx_hi_pending     <= 1'b0;
			phy_pipe_tx_data  <= tx_hi_data;
			phy_pipe_tx_datak <= tx_hi_datak;
		end else begin
			phy_pipe_tx_data  <= '0;
			phy_pipe_tx_datak <= '0;
		end
	end

	always_ff @(posedge local_pclk_half) begin
		if (tx_take) begin
			tx_hi_data  <= link_out_word.data[`USB3_LINK_W-1:`USB3_PIPE_W];
			tx_hi_datak <= link_out_word.datak[`USB3_LINK_KW-1:`USB3_PIPE_KW];
		end
	end

	// upstream must see a dead cycle while the high half drains
	a_ready_gap: assert property (@(posedge local_pclk_half) disable iff (!rst_n)
		tx_take |=> !link_out_ready);

endmodule

//--- usb3_word_fifo.sv
// usb3 lite word fifo
`timescale 1ns/1ns
`include "usb3_lite_consts.svh"

module usb3_word_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  DEPTH     = `USB3_FIFO_DEPTH
) (
	input  logic     local_pclk_half,
	input  logic     rst_n,
	input  logic     push,
	input  payload_t push_data,
	input  logic     pop,
	output payload_t pop_data,
	output logic     empty,
	output logic     full
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	payload_t        mem [DEPTH];
	logic [AW-1:0]   wr_ptr;
	logic [AW-1:0]   rd_ptr;
	logic [CW-1:0]   count;

	assign empty    = (count == '0);
	assign full     = (count == CW'(DEPTH));
	assign pop_data = mem[rd_ptr];	// head is visible without a pop

	always_ff @(posedge local_pclk_half) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge local_pclk_half) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	// callers are expected to gate their strobes with the flags
	a_no_push_full: assert property (@(posedge local_pclk_half) disable iff (!rst_n)
		push |-> !full);
	a_no_pop_empty: assert property (@(posedge local_pclk_half) disable iff (!rst_n)
		pop |-> !empty);

endmodule

//--- usb3_pkg.sv
// usb3 lite types
`include "usb3_lite_consts.svh"

package usb3_pkg;

	////////////////////////////////////////
	// link training states
	////////////////////////////////////////

	typedef enum logic [`USB3_STATE_W-1:0] {
		DISABLED  = 3'd0,
		RX_DETECT = 3'd1,
		POLLING   = 3'd2,
		U0        = 3'd3
	} ltssm_state_t;

	////////////////////////////////////////
	// link word
	////////////////////////////////////////

	// one k flag per data byte with byte 0 in the low bits
	typedef struct packed {
		logic [`USB3_LINK_KW-1:0] datak;
		logic [`USB3_LINK_W-1:0]  data;
	} link_word_t;

endpackage

//--- usb3_lite_consts.svh
// usb3 lite constants
`ifndef USB3_LITE_CONSTS_SVH
`define USB3_LITE_CONSTS_SVH

// bus and datapath widths
`define USB3_APB_AW         8
`define USB3_APB_DW         32
`define USB3_PIPE_W         16
`define USB3_PIPE_KW        2
`define USB3_LINK_W         32
`define USB3_LINK_KW        4
`define USB3_STATE_W        3

`define USB3_FIFO_DEPTH     8
`define USB3_TS_NEEDED      8   // consecutive training words to leave polling

`define USB3_K_COM          8'hBC
`define USB3_RXSTAT_PRESENT 3'b011
`define USB3_STRAP_MARGIN   3'b011  // driven on tx_margin while in reset

// apb register map
`define USB3_A_CTRL         8'h00
`define USB3_A_STATUS       8'h04
`define USB3_A_TXK          8'h08
`define USB3_A_TXDATA       8'h0C
`define USB3_A_RXK          8'h10
`define USB3_A_RXDATA       8'h14
`define USB3_A_RXCNT        8'h18

`endif
